// File: map_settings.svh
`ifndef MAP_SETTINGS_SVH
`define MAP_SETTINGS_SVH

// map and vga coordinate width
`define MAP_COORD_W 10

// sprite memory address width
`define MAP_ADDR_W 17

// sprite memory row length in pixels
`define MAP_STRIDE 320

// object table size and index width
`define MAP_NUM_OBJ 12
`define MAP_IDX_W 4

// player box in map pixels
`define PLAYER_W 12
`define PLAYER_H 16

`endif

// File: game_pkg.sv
`include "map_settings.svh"

package game_pkg;

    // what an object does to a player
    // doors only draw, the probe ignores them
    typedef enum logic [1:0] {
        kind_solid  = 2'd0,
        kind_hazard = 2'd1,
        kind_door   = 2'd2
    } obj_kind_t;

    // one table entry, covers [pivot, pivot + size) in map space
    typedef struct packed {
        logic                    en;
        obj_kind_t               kind;
        logic [`MAP_COORD_W-1:0] pivot_h;
        logic [`MAP_COORD_W-1:0] pivot_v;
        logic [`MAP_COORD_W-1:0] width;
        logic [`MAP_COORD_W-1:0] height;
        // image origin in sprite memory
        logic [`MAP_COORD_W-1:0] mem_h;
        logic [`MAP_COORD_W-1:0] mem_v;
    } map_obj_t;

    // screen pixel on the 640x480 raster
    typedef struct packed {
        logic [`MAP_COORD_W-1:0] vga_h;
        logic [`MAP_COORD_W-1:0] vga_v;
    } pixel_t;

    // top-left corner of a player box in map space
    typedef struct packed {
        logic [`MAP_COORD_W-1:0] x;
        logic [`MAP_COORD_W-1:0] y;
    } player_pos_t;

    typedef struct packed {
        logic collision;
        logic land;
        logic hazard;
    } player_status_t;

endpackage

// File: map_regs.sv
`timescale 1ns/100ps
`include "map_settings.svh"

module map_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cfg_wr,
    input  logic [`MAP_IDX_W-1:0]  cfg_idx,
    input  game_pkg::map_obj_t     cfg_obj,
    output game_pkg::map_obj_t     objs [`MAP_NUM_OBJ]
);
    import game_pkg::*;

    localparam int num_obj = `MAP_NUM_OBJ;

    map_obj_t           obj_q [num_obj];
    logic [num_obj-1:0] wr_sel;

    // one-hot entry select, indices past the table fall through
    always_comb begin
        wr_sel = '0;
        if (cfg_wr && (cfg_idx < num_obj)) begin
            wr_sel[cfg_idx] = 1'b1;
        end
    end

    // reset only drops the enables, geometry stays as it was
    always_ff @(posedge clk) begin
        for (int i = 0; i < num_obj; i++) begin
            if (reset) begin
                obj_q[i].en <= 1'b0;
            end else if (wr_sel[i]) begin
                obj_q[i] <= cfg_obj;
            end
        end
    end

    // render and probe both see the table directly
    assign objs = obj_q;

endmodule

// File: terrain_sprite.sv
`timescale 1ns/100ps
`include "map_settings.svh"

module terrain_sprite (
    input  game_pkg::map_obj_t       obj,
    input  logic [`MAP_COORD_W-1:0]  h,
    input  logic [`MAP_COORD_W-1:0]  v,
    output logic                     hit,
    output logic [`MAP_ADDR_W-1:0]   addr
);
    localparam int addr_w = `MAP_ADDR_W;
    localparam logic [`MAP_ADDR_W-1:0] stride = `MAP_STRIDE;

    // one extra bit so pivot + size cannot wrap
    logic [`MAP_COORD_W:0]  h_end;
    logic [`MAP_COORD_W:0]  v_end;
    logic                   in_h;
    logic                   in_v;
    logic [`MAP_ADDR_W-1:0] row;
    logic [`MAP_ADDR_W-1:0] col;

    assign h_end = obj.pivot_h + obj.width;
    assign v_end = obj.pivot_v + obj.height;

    // right and bottom edges are exclusive
    assign in_h = (h >= obj.pivot_h) && (h < h_end);
    assign in_v = (v >= obj.pivot_v) && (v < v_end);
    assign hit  = obj.en && in_h && in_v;

    // offset into the object, moved to its image origin
    assign row = addr_w'(obj.mem_v) + addr_w'(v) - addr_w'(obj.pivot_v);
    assign col = addr_w'(obj.mem_h) + addr_w'(h) - addr_w'(obj.pivot_h);

    // wraps modulo 2^17 like the sprite memory
    assign addr = row * stride + col;

endmodule

// File: map_render.sv
`timescale 1ns/100ps
`include "map_settings.svh"

module map_render (
    input  logic                    clk,
    input  logic                    reset,
    input  game_pkg::map_obj_t      objs [`MAP_NUM_OBJ],
    input  logic                    pix_valid,
    input  game_pkg::pixel_t        pix,
    output logic                    addr_valid,
    output logic [`MAP_ADDR_W-1:0]  addr
);
    localparam int num_obj = `MAP_NUM_OBJ;
    localparam int addr_w = `MAP_ADDR_W;
    localparam logic [`MAP_ADDR_W-1:0] stride = `MAP_STRIDE;

    // map coordinate of the incoming pixel
    logic [`MAP_COORD_W-1:0] h;
    logic [`MAP_COORD_W-1:0] v;

    logic [num_obj-1:0]      hit_c;
    logic [`MAP_ADDR_W-1:0]  addr_c [num_obj];
    logic [`MAP_ADDR_W-1:0]  bg_c;

    // stage 1 registers
    logic                    s1_valid;
    logic [num_obj-1:0]      s1_hit;
    logic [`MAP_ADDR_W-1:0]  s1_addr [num_obj];
    logic [`MAP_ADDR_W-1:0]  s1_bg;

    logic [`MAP_ADDR_W-1:0]  sel_addr;

    // half resolution map
    assign h = pix.vga_h >> 1;
    assign v = pix.vga_v >> 1;

    // background image is a full screen at the start of memory
    assign bg_c = addr_w'(v) * stride + addr_w'(h);

    for (genvar i = 0; i < num_obj; i++) begin : g_obj
        terrain_sprite terrain_sprite_inst (
            .obj  (objs[i]),
            .h    (h),
            .v    (v),
            .hit  (hit_c[i]),
            .addr (addr_c[i])
        );
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= pix_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_hit  <= hit_c;
        s1_addr <= addr_c;
        s1_bg   <= bg_c;
    end

    // lowest index wins, so scan downward and let it overwrite
    always_comb begin
        sel_addr = s1_bg;
        for (int i = num_obj - 1; i >= 0; i--) begin
            if (s1_hit[i]) begin
                sel_addr = s1_addr[i];
            end
        end
    end

    // stage 2, output holds between pixels
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_valid <= 1'b0;
            addr       <= '0;
        end else begin
            addr_valid <= s1_valid;
            if (s1_valid) begin
                addr <= sel_addr;
            end
        end
    end

endmodule

// File: player_probe.sv
`timescale 1ns/100ps
`include "map_settings.svh"

module player_probe (
    input  logic                      clk,
    input  logic                      reset,
    input  game_pkg::map_obj_t        objs [`MAP_NUM_OBJ],
    input  logic                      pos_valid,
    input  game_pkg::player_pos_t     p1_pos,
    input  game_pkg::player_pos_t     p2_pos,
    output logic                      status_valid,
    output game_pkg::player_status_t  p1_status,
    output game_pkg::player_status_t  p2_status
);
    import game_pkg::*;

    localparam int num_obj = `MAP_NUM_OBJ;
    localparam logic [`MAP_COORD_W:0] box_w = `PLAYER_W;
    localparam logic [`MAP_COORD_W:0] box_h = `PLAYER_H;

    player_status_t p1_next;
    player_status_t p2_next;

    // box against every entry, results ORed per kind
    function automatic player_status_t check_box(
        input player_pos_t pos,
        input map_obj_t    tbl [num_obj]
    );
        player_status_t        st;
        logic [`MAP_COORD_W:0] box_r;
        logic [`MAP_COORD_W:0] box_b;
        logic [`MAP_COORD_W:0] obj_r;
        logic [`MAP_COORD_W:0] obj_b;
        logic                  cols;
        logic                  rows;

        st    = '0;
        box_r = pos.x + box_w;
        box_b = pos.y + box_h;
        for (int i = 0; i < num_obj; i++) begin
            obj_r = tbl[i].pivot_h + tbl[i].width;
            obj_b = tbl[i].pivot_v + tbl[i].height;
            cols  = (pos.x < obj_r) && (box_r > tbl[i].pivot_h);
            rows  = (pos.y < obj_b) && (box_b > tbl[i].pivot_v);
            if (tbl[i].en && tbl[i].kind == kind_solid) begin
                st.collision |= cols && rows;
                // feet rest on the top row, one below the box
                st.land |= cols && (box_b == tbl[i].pivot_v);
            end
            if (tbl[i].en && tbl[i].kind == kind_hazard) begin
                st.hazard |= cols && rows;
            end
        end
        return st;
    endfunction

    always_comb begin
        p1_next = check_box(p1_pos, objs);
        p2_next = check_box(p2_pos, objs);
    end

    // status held until the next position strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            status_valid <= 1'b0;
            p1_status    <= '0;
            p2_status    <= '0;
        end else begin
            status_valid <= pos_valid;
            if (pos_valid) begin
                p1_status <= p1_next;
                p2_status <= p2_next;
            end
        end
    end

endmodule

// File: map_top.sv
`timescale 1ns/100ps
`include "map_settings.svh"

module map_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cfg_wr,
    input  logic [`MAP_IDX_W-1:0]     cfg_idx,
    input  game_pkg::map_obj_t        cfg_obj,
    input  logic                      pix_valid,
    input  game_pkg::pixel_t          pix,
    output logic                      addr_valid,
    output logic [`MAP_ADDR_W-1:0]    addr,
    input  logic                      pos_valid,
    input  game_pkg::player_pos_t     p1_pos,
    input  game_pkg::player_pos_t     p2_pos,
    output logic                      status_valid,
    output game_pkg::player_status_t  p1_status,
    output game_pkg::player_status_t  p2_status
);
    import game_pkg::*;

    // shared object table
    map_obj_t objs [`MAP_NUM_OBJ];

    map_regs map_regs_inst (
        .clk     (clk),
        .reset   (reset),
        .cfg_wr  (cfg_wr),
        .cfg_idx (cfg_idx),
        .cfg_obj (cfg_obj),
        .objs    (objs)
    );

    map_render map_render_inst (
        .clk        (clk),
        .reset      (reset),
        .objs       (objs),
        .pix_valid  (pix_valid),
        .pix        (pix),
        .addr_valid (addr_valid),
        .addr       (addr)
    );

    player_probe player_probe_inst (
        .clk          (clk),
        .reset        (reset),
        .objs         (objs),
        .pos_valid    (pos_valid),
        .p1_pos       (p1_pos),
        .p2_pos       (p2_pos),
        .status_valid (status_valid),
        .p1_status    (p1_status),
        .p2_status    (p2_status)
    );

endmodule

// File: map_assert.sv
`timescale 1ns/100ps

module map_assert (
    input logic                      clk,
    input logic                      reset,
    input logic                      pix_valid,
    input logic                      addr_valid,
    input logic                      pos_valid,
    input logic                      status_valid,
    input game_pkg::player_status_t  p1_status,
    input game_pkg::player_status_t  p2_status
);

    // render latency is exactly two cycles, back to back pixels included
    addr_latency: assert property (@(posedge clk) disable iff (reset)
        addr_valid == $past(pix_valid, 2))
        else $error("addr_valid is not two cycles after pix_valid");

    // probe answers one cycle after the strobe
    status_latency: assert property (@(posedge clk) disable iff (reset)
        status_valid == $past(pos_valid))
        else $error("status_valid is not one cycle after pos_valid");

    // status holds between strobes
    status_hold: assert property (@(posedge clk) disable iff (reset)
        !$stable({p1_status, p2_status}) |-> $past(pos_valid))
        else $error("player status changed without pos_valid");

endmodule

bind map_top map_assert map_assert_inst (
    .clk          (clk),
    .reset        (reset),
    .pix_valid    (pix_valid),
    .addr_valid   (addr_valid),
    .pos_valid    (pos_valid),
    .status_valid (status_valid),
    .p1_status    (p1_status),
    .p2_status    (p2_status)
);

// File: map_tb.sv
`timescale 1ns/100ps
`include "map_settings.svh"

module map_tb;
    import game_pkg::*;

    localparam string stim_path = "map_stimulus.txt";

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    cfg_wr;
    logic [`MAP_IDX_W-1:0]   cfg_idx;
    map_obj_t                cfg_obj;
    logic                    pix_valid;
    pixel_t                  pix;
    logic                    addr_valid;
    logic [`MAP_ADDR_W-1:0]  addr;
    logic                    pos_valid;
    player_pos_t             p1_pos;
    player_pos_t             p2_pos;
    logic                    status_valid;
    player_status_t          p1_status;
    player_status_t          p2_status;

    // expected addresses of pixels still in the pipeline
    logic [31:0] exp_addr_q [$];
    int          line_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    map_top map_top_inst (
        .clk          (clk),
        .reset        (reset),
        .cfg_wr       (cfg_wr),
        .cfg_idx      (cfg_idx),
        .cfg_obj      (cfg_obj),
        .pix_valid    (pix_valid),
        .pix          (pix),
        .addr_valid   (addr_valid),
        .addr         (addr),
        .pos_valid    (pos_valid),
        .p1_pos       (p1_pos),
        .p2_pos       (p2_pos),
        .status_valid (status_valid),
        .p1_status    (p1_status),
        .p2_status    (p2_status)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("** Error: %s is 0x%0h, expected 0x%0h",
                                name, got, expected));
        end
    endtask

    // limit is only known once the stimulus has been counted
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            abort_run($sformatf("Error: timeout reached after %0d cycles", cycle_count));
        end
    end

    // outputs sampled on the falling edge before any input changes
    task automatic next_cycle();
        @(negedge clk);
        if (addr_valid) begin
            if (exp_addr_q.size() == 0) begin
                abort_run("Error: addr_valid pulsed with no pixel in flight");
            end else begin
                check_value("addr", addr, exp_addr_q.pop_front());
            end
        end
    endtask

    task automatic set_idle();
        cfg_wr    = 1'b0;
        pix_valid = 1'b0;
        pos_valid = 1'b0;
    endtask

    task automatic write_entry(input logic [31:0] idx, input map_obj_t obj);
        next_cycle();
        set_idle();
        cfg_wr  = 1'b1;
        cfg_idx = idx[`MAP_IDX_W-1:0];
        cfg_obj = obj;
    endtask

    task automatic send_pixel(input logic [31:0] vga_h, input logic [31:0] vga_v,
                              input logic [31:0] expected);
        next_cycle();
        set_idle();
        pix_valid = 1'b1;
        pix.vga_h = vga_h[`MAP_COORD_W-1:0];
        pix.vga_v = vga_v[`MAP_COORD_W-1:0];
        exp_addr_q.push_back(expected);
    endtask

    task automatic probe_players(input logic [31:0] p1_x, input logic [31:0] p1_y,
                                 input logic [31:0] p2_x, input logic [31:0] p2_y,
                                 input logic [31:0] exp1, input logic [31:0] exp2);
        int waited;

        next_cycle();
        set_idle();
        pos_valid = 1'b1;
        p1_pos.x  = p1_x[`MAP_COORD_W-1:0];
        p1_pos.y  = p1_y[`MAP_COORD_W-1:0];
        p2_pos.x  = p2_x[`MAP_COORD_W-1:0];
        p2_pos.y  = p2_y[`MAP_COORD_W-1:0];
        next_cycle();
        pos_valid = 1'b0;
        waited = 0;
        while (!status_valid && waited < 4) begin
            next_cycle();
            waited++;
        end
        if (!status_valid) begin
            abort_run("Error: status_valid never pulsed after pos_valid");
        end else begin
            check_value("p1_status", p1_status, exp1);
            check_value("p2_status", p2_status, exp2);
        end
    endtask

    task automatic drain_pixels();
        int waited;

        next_cycle();
        set_idle();
        waited = 0;
        while (exp_addr_q.size() > 0 && waited < 4) begin
            next_cycle();
            waited++;
        end
        if (exp_addr_q.size() > 0) begin
            abort_run("Error: addr_valid missing for a pixel that was sent");
        end
    endtask

    task automatic count_lines();
        string line;
        int    fd;

        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            abort_run("Error: cannot open the stimulus file");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 0 && (line[0] == "C" || line[0] == "P" || line[0] == "Q")) begin
                    line_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_stimulus();
        string       tag;
        string       rest;
        int          fd;
        int          n;
        logic [31:0] fld [9];
        map_obj_t    obj;

        fd = $fopen(stim_path, "r");
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "C") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                            fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
                if (n != 9) begin
                    abort_run("Error: config line in the stimulus file is short");
                end
                obj.en      = fld[1][0];
                obj.kind    = obj_kind_t'(fld[2][1:0]);
                obj.pivot_h = fld[3][`MAP_COORD_W-1:0];
                obj.pivot_v = fld[4][`MAP_COORD_W-1:0];
                obj.width   = fld[5][`MAP_COORD_W-1:0];
                obj.height  = fld[6][`MAP_COORD_W-1:0];
                obj.mem_h   = fld[7][`MAP_COORD_W-1:0];
                obj.mem_v   = fld[8][`MAP_COORD_W-1:0];
                write_entry(fld[0], obj);
            end else if (tag == "P") begin
                n = $fscanf(fd, "%h %h %h", fld[0], fld[1], fld[2]);
                if (n != 3) begin
                    abort_run("Error: pixel line in the stimulus file is short");
                end
                send_pixel(fld[0], fld[1], fld[2]);
            end else if (tag == "Q") begin
                n = $fscanf(fd, "%h %h %h %h %h %h", fld[0], fld[1], fld[2],
                            fld[3], fld[4], fld[5]);
                if (n != 6) begin
                    abort_run("Error: player line in the stimulus file is short");
                end
                probe_players(fld[0], fld[1], fld[2], fld[3], fld[4], fld[5]);
            end else if (tag.substr(0, 0) == "#") begin
                n = $fgets(rest, fd);
            end else begin
                abort_run({"Error: unknown line kind in the stimulus file: ", tag});
            end
        end
        $fclose(fd);
    endtask

    initial begin
        reset   = 1'b1;
        cfg_idx = '0;
        cfg_obj = '0;
        pix     = '0;
        p1_pos  = '0;
        p2_pos  = '0;
        set_idle();
        count_lines();
        cycle_limit = 8 * line_count + 100;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        // nothing comes out before the first strobe
        repeat (2) begin
            next_cycle();
            check_value("status_valid", status_valid, 32'h0);
        end
        check_value("addr", addr, 32'h0);
        check_value("p1_status", p1_status, 32'h0);
        check_value("p2_status", p2_status, 32'h0);
        run_stimulus();
        drain_pixels();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: map_stimulus.txt
# C idx en kind pivot_h pivot_v width height mem_h mem_v | P vga_h vga_v addr
# Q p1_x p1_y p2_x p2_y p1_status p2_status, status is {collision land hazard}, all hex
# empty table gives the background image
P 000 000 00000
P 001 001 00000
P 002 002 00141
P 013 00b 00649
P 27f 1df 12bff
Q 020 020 050 050 0 0
# wall, river, door over the wall corner, small door with a wrapped image
C 0 1 0 040 060 020 010 100 010
C 1 1 1 080 0a0 030 008 000 0f0
C 2 1 2 050 064 010 010 120 020
C 3 1 2 010 010 004 004 000 1ff
# index past the table is dropped
C c 1 0 000 000 140 0f0 000 000
P 000 000 00000
# wall corners, inside, then one past each edge
P 080 0c0 01500
P 0bf 0df 027df
P 08c 0c8 01a06
P 0c0 0c0 07860
P 080 0e0 08c40
P 07e 0c8 07d3f
P 08c 0be 07706
# river, door, wrapped door image
P 104 14a 13242
P 0b8 0e4 03aac
P 020 020 07ec0
# wall over door
P 0b0 0d0 01f18
# land and collision, river and door, left edge of the wall
Q 040 050 044 060 2 4
Q 088 09c 058 070 1 0
Q 034 060 035 060 0 4
# wall switched off, door shows through
C 0 0 0 040 060 020 010 100 010
P 0b0 0d0 02e28
P 080 0c0 07840
Q 040 050 044 060 0 0

// File: compile.f
+incdir+.
game_pkg.sv
map_regs.sv
terrain_sprite.sv
map_render.sv
player_probe.sv
map_top.sv
map_assert.sv
map_tb.sv

// File: run.sh
#!/bin/sh
# builds the map testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module map_tb -f compile.f -o map_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/map_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1
